// ==== Bender.yml ====
package:
  name: fp_mul_unit

sources:
  - files:
      - src/fp_pkg.sv
      - src/mul_pipe_pkg.sv
      - src/fp_req_buffer.sv
      - src/fp_mul_lane.sv
      - src/fp_mul_pipe.sv
      - src/fp_resp_buffer.sv
      - src/fp_mul_unit.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_fp_mul_unit.sv

// ==== all.f ====
src/fp_pkg.sv
src/mul_pipe_pkg.sv
src/fp_req_buffer.sv
src/fp_mul_lane.sv
src/fp_mul_pipe.sv
src/fp_resp_buffer.sv
src/fp_mul_unit.sv
+incdir+sim
sim/tb_fp_mul_unit.sv

// ==== sim/fp_ref_model.svh ====
`ifndef FP_REF_MODEL_SVH
`define FP_REF_MODEL_SVH

// ========================================
// FP32 multiply reference, {invalid, overflow, result}
// ========================================
function automatic logic [33:0] ref_fmul(input logic [31:0] a, input logic [31:0] b);
    logic        sign;
    logic        a_nan, a_inf, a_zero;
    logic        b_nan, b_inf, b_zero;
    int          e;
    logic [47:0] p;
    logic [24:0] m;
    logic [23:0] rem;
    sign   = a[31] ^ b[31];
    a_nan  = (&a[30:23]) && (|a[22:0]);
    a_inf  = (&a[30:23]) && !(|a[22:0]);
    a_zero = !(|a[30:23]);          // subnormals count as zero
    b_nan  = (&b[30:23]) && (|b[22:0]);
    b_inf  = (&b[30:23]) && !(|b[22:0]);
    b_zero = !(|b[30:23]);
    if (a_nan || b_nan || (a_inf && b_zero) || (a_zero && b_inf))
        return {2'b10, QNAN_CANON};
    if (a_inf || b_inf)
        return {2'b00, sign, 8'hff, 23'd0};
    if (a_zero || b_zero)
        return {2'b00, sign, 31'd0};
    p = {25'd1, a[22:0]} * {25'd1, b[22:0]};
    e = int'(a[30:23]) + int'(b[30:23]) - int'(FP_BIAS);
    if (p[47])
        e = e + 1;
    else
        p = p << 1;                 // leading one now at bit 47
    m   = {1'b0, p[47:24]};
    rem = p[23:0];
    // above half rounds up, exact half goes to the even neighbour
    if (rem > 24'h80_0000 || (rem == 24'h80_0000 && m[0]))
        m = m + 1;
    if (m[24]) begin
        e = e + 1;
        m = m >> 1;
    end
    if (e >= 255)
        return {2'b01, sign, 8'hff, 23'd0};
    if (e <= 0)
        return {2'b00, sign, 31'd0};
    return {2'b00, sign, e[7:0], m[22:0]};
endfunction

// fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

`endif

// ==== sim/tb_fp_mul_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fp_mul_unit
    import fp_pkg::*, mul_pipe_pkg::*;
;

    localparam int NUM_THREADS  = 4;
    localparam int TAG_W        = 6;
    localparam int CLK_PERIOD   = 20;
    localparam int NUM_DIRECTED = 9;
    localparam int NUM_RANDOM   = 300;
    localparam int LATENCY      = 4;   // input transfer edge to output transfer edge

    `include "fp_ref_model.svh"

    logic                         clk;
    logic                         rst_n;
    logic                         in_valid;
    logic [TAG_W-1:0]             in_tag;
    logic [NUM_THREADS-1:0][31:0] dataa;
    logic [NUM_THREADS-1:0][31:0] datab;
    logic                         in_ready;
    logic                         out_valid;
    logic [TAG_W-1:0]             out_tag;
    logic [NUM_THREADS-1:0][31:0] result;
    logic [NUM_THREADS-1:0]       out_invalid;
    logic [NUM_THREADS-1:0]       out_overflow;
    logic                         out_ready;

    int               errors;
    int               checks;
    int               cycle;
    logic [31:0]      lfsr_q;
    logic             rand_ready;
    logic [TAG_W-1:0] next_tag;

    // one expected record per accepted request
    logic [TAG_W-1:0]             tag_q [$];
    logic [NUM_THREADS-1:0][33:0] rec_q [$];
    string                        name_q [$];
    int                           cyc_q [$];   // -1 means no latency check

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    fp_mul_unit #(.NUM_THREADS(NUM_THREADS), .TAG_W(TAG_W)) fp_mul_unit_inst (
        .clk(clk), .rst_n(rst_n),
        .in_valid(in_valid), .in_tag(in_tag), .dataa(dataa), .datab(datab),
        .in_ready(in_ready),
        .out_valid(out_valid), .out_tag(out_tag), .result(result),
        .out_invalid(out_invalid), .out_overflow(out_overflow),
        .out_ready(out_ready)
    );

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // mostly mid-range exponents with a fully random word now and then
    function automatic logic [31:0] rand_operand();
        if (take_bits(3) == 0)
            return take_bits(32);
        return {take_bits(1) != 0, 8'd96 + 8'(take_bits(6)), 23'(take_bits(23))};
    endfunction

    task automatic log_mismatch(input string name, input string what,
                                input logic [63:0] expected, input logic [63:0] actual);
        errors++;
        $display("CHECK FAILED %s %s: expected %0h, actual %0h", name, what, expected, actual);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
        if (rand_ready)
            out_ready = take_bits(1) != 0;
    endtask

    // starts and ends 2 ns past a rising edge
    task automatic send_req(input string name, input logic [NUM_THREADS-1:0][31:0] a,
                            input logic [NUM_THREADS-1:0][31:0] b, input bit chk_lat);
        logic [NUM_THREADS-1:0][33:0] rec;
        for (int i = 0; i < NUM_THREADS; i++)
            rec[i] = ref_fmul(a[i], b[i]);
        in_valid = 1'b1;
        in_tag   = next_tag;
        dataa    = a;
        datab    = b;
        @(negedge clk);
        while (!in_ready) begin
            next_cycle();
            @(negedge clk);
        end
        tag_q.push_back(next_tag);
        rec_q.push_back(rec);
        name_q.push_back(name);
        cyc_q.push_back(chk_lat ? cycle : -1);
        next_tag++;
        next_cycle();
        in_valid = 1'b0;
    endtask

    // ========================================
    // compare
    // ========================================
    always @(negedge clk) begin : monitor
        logic [TAG_W-1:0]             etag;
        logic [NUM_THREADS-1:0][33:0] erec;
        string                        ename;
        int                           t0;
        if (rst_n && out_valid && out_ready) begin
            assert (tag_q.size() != 0) else begin
                errors++;
                $display("output with tag %0h arrived with no request pending", out_tag);
            end
            if (tag_q.size() != 0) begin
                etag  = tag_q.pop_front();
                erec  = rec_q.pop_front();
                ename = name_q.pop_front();
                t0    = cyc_q.pop_front();
                checks++;
                assert (out_tag == etag) else log_mismatch(ename, "tag", etag, out_tag);
                for (int i = 0; i < NUM_THREADS; i++) begin
                    assert ({out_invalid[i], out_overflow[i], result[i]} == erec[i])
                    else log_mismatch(ename, $sformatf("lane %0d", i), erec[i],
                                      {out_invalid[i], out_overflow[i], result[i]});
                end
                if (t0 >= 0) begin
                    assert (cycle - t0 == LATENCY)
                    else log_mismatch(ename, "latency", LATENCY, cycle - t0);
                end
            end
        end
    end

    initial begin : watchdog
        #((200 + 20 * (NUM_DIRECTED + NUM_RANDOM)) * CLK_PERIOD);
        $display("timeout after %0d cycles with %0d results still pending", cycle, tag_q.size());
        $display("Test failed");
        $finish;
    end

    // ========================================
    // stimulus
    // ========================================
    initial begin : stimulus
        logic [NUM_THREADS-1:0][31:0] ra;
        logic [NUM_THREADS-1:0][31:0] rb;
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_tag     = '0;
        dataa      = '0;
        datab      = '0;
        out_ready  = 1'b1;
        errors     = 0;
        checks     = 0;
        cycle      = 0;
        lfsr_q     = 32'hecd79de1;
        rand_ready = 1'b0;
        next_tag   = '0;
        repeat (10) begin
            @(negedge clk);
            assert (!in_ready && !out_valid) else begin
                errors++;
                $display("in_ready or out_valid high while reset is asserted");
            end
        end
        @(posedge clk);
        #2;
        rst_n = 1'b1;
        next_cycle();
        assert (in_ready) else begin
            errors++;
            $display("in_ready did not rise one cycle after reset release");
        end

        send_req("basic", {4{32'h3fc0_0000}}, {4{32'h4000_0000}}, 1);
        send_req("basic", {4{32'hc040_0000}}, {4{32'h3e80_0000}}, 1);
        send_req("basic", {32'h3f80_0000, 32'h40e0_0000, 32'hc040_0000, 32'h3fc0_0000},
                          {32'h3f80_0000, 32'hbf00_0000, 32'h3e80_0000, 32'h4000_0000}, 1);
        // ties, sticky bits and carry-out into the exponent
        send_req("rounding", {32'h3fff_ffff, 32'h3fc0_0000, 32'h3fff_ffff, 32'h3f80_0001},
                             {32'h3fff_ffff, 32'h3f80_0003, 32'h3f80_0001, 32'h3fc0_0000}, 0);
        send_req("rounding", {32'h3f7f_fffe, 32'h4049_0fdb, 32'h3fa0_0001, 32'h3f80_0001},
                             {32'h3f80_0001, 32'h4049_0fdb, 32'h3fa0_0003, 32'h3f80_0001}, 0);
        send_req("special", {32'h7f80_0000, 32'h7f80_0000, 32'hff80_0001, 32'h7fc0_0000},
                            {32'hc000_0000, 32'h0000_0000, 32'h0000_0000, 32'h3f80_0000}, 0);
        send_req("special", {32'h007f_ffff, 32'h0000_0001, 32'h8000_0000, 32'h0000_0000},
                            {32'h7f80_0000, 32'h3f80_0000, 32'h3f80_0000, 32'h4040_0000}, 0);
        send_req("overflow", {32'h0080_0000, 32'h7f7f_ffff, 32'hff00_0000, 32'h7f00_0000},
                             {32'h0080_0000, 32'h3f80_0001, 32'h7f00_0000, 32'h4000_0000}, 0);
        send_req("flush", {32'h7f7f_ffff, 32'h0080_0000, 32'h0da2_4260, 32'h8080_0000},
                          {32'hbf80_0000, 32'h3f80_0000, 32'h0da2_4260, 32'h3f00_0000}, 0);

        rand_ready = 1'b1;
        repeat (NUM_RANDOM) begin
            while (take_bits(1) != 0)
                next_cycle();   // idle gap on the input
            for (int i = 0; i < NUM_THREADS; i++) begin
                ra[i] = rand_operand();
                rb[i] = rand_operand();
            end
            send_req("random", ra, rb, 0);
        end
        while (tag_q.size() != 0)
            next_cycle();
        rand_ready = 1'b0;
        out_ready  = 1'b1;
        repeat (5) next_cycle();   // catch any extra output

        $display("errors: %0d in %0d checked results", errors, checks);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/fp_mul_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_mul_lane
    import fp_pkg::*, mul_pipe_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         enable,
    input  wire  [31:0] a,
    input  wire  [31:0] b,
    output logic [31:0] result,
    output logic        invalid,
    output logic        overflow
);

    localparam int unsigned SIG_W  = FP_MAN_W + 1;   // significand with hidden one
    localparam int unsigned PROD_W = 2 * SIG_W;
    localparam int unsigned EXP_SW = FP_EXP_W + 2;   // signed room for sum and carries
    localparam int          EXP_MAX = (1 << FP_EXP_W) - 1;
    localparam logic [30:0] INF_MAG = {{FP_EXP_W{1'b1}}, {FP_MAN_W{1'b0}}};

    // ========================================
    // stage 1: classify, add exponents, multiply
    // ========================================
    fp32_word_u ua;
    fp32_word_u ub;
    logic a_zero, a_inf, a_nan;
    logic b_zero, b_inf, b_nan;
    logic signed [EXP_SW-1:0] exp_sum;
    logic [PROD_W-1:0] prod;

    assign ua = a;
    assign ub = b;

    assign a_nan  = ua.bits[30:0] > INF_MAG;
    assign a_inf  = ua.bits[30:0] == INF_MAG;
    assign a_zero = ua.bits[30:FP_MAN_W] == '0;   // subnormals read as zero
    assign b_nan  = ub.bits[30:0] > INF_MAG;
    assign b_inf  = ub.bits[30:0] == INF_MAG;
    assign b_zero = ub.bits[30:FP_MAN_W] == '0;

    assign exp_sum = EXP_SW'(ua.fields.exponent) + EXP_SW'(ub.fields.exponent)
                   - EXP_SW'(FP_BIAS);
    assign prod = {1'b1, ua.fields.mantissa} * {1'b1, ub.fields.mantissa};

    logic                     s1_invalid, s1_inf, s1_zero;
    logic                     s1_sign;
    logic signed [EXP_SW-1:0] s1_exp;
    logic [PROD_W-1:0]        s1_prod;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_invalid <= 1'b0;
            s1_inf     <= 1'b0;
            s1_zero    <= 1'b0;
        end else if (enable) begin
            s1_invalid <= a_nan | b_nan | (a_inf & b_zero) | (a_zero & b_inf);
            s1_inf     <= a_inf | b_inf;
            s1_zero    <= a_zero | b_zero;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            s1_sign <= ua.fields.sign ^ ub.fields.sign;
            s1_exp  <= exp_sum;
            s1_prod <= prod;
        end
    end

    // ========================================
    // stage 2: normalize, round, pack
    // ========================================
    logic                     msb;
    logic [SIG_W-1:0]         norm_sig;
    logic                     guard, sticky, round_up, carry;
    logic [SIG_W:0]           rounded;
    logic signed [EXP_SW-1:0] exp_final;
    fp32_word_u               res_u;
    logic                     inv_d, ovf_d;

    assign msb = s1_prod[PROD_W-1];   // product in [2,4)

    always_comb begin
        if (msb) begin
            norm_sig = s1_prod[PROD_W-1 -: SIG_W];
            guard    = s1_prod[PROD_W-1-SIG_W];
            sticky   = |s1_prod[PROD_W-2-SIG_W:0];
        end else begin
            norm_sig = s1_prod[PROD_W-2 -: SIG_W];
            guard    = s1_prod[PROD_W-2-SIG_W];
            sticky   = |s1_prod[PROD_W-3-SIG_W:0];
        end
    end

    assign round_up = guard & (sticky | norm_sig[0]);   // ties go to even
    assign rounded  = {1'b0, norm_sig} + (SIG_W+1)'(round_up);
    assign carry    = rounded[SIG_W];   // low bits are all zero on carry-out
    assign exp_final = s1_exp + EXP_SW'(msb) + EXP_SW'(carry);

    always_comb begin
        res_u.fields.sign     = s1_sign;
        res_u.fields.exponent = exp_final[FP_EXP_W-1:0];
        res_u.fields.mantissa = rounded[FP_MAN_W-1:0];
        inv_d = 1'b0;
        ovf_d = 1'b0;
        if (s1_invalid) begin
            res_u.bits = QNAN_CANON;
            inv_d      = 1'b1;
        end else if (s1_inf) begin
            res_u.fields.exponent = '1;
            res_u.fields.mantissa = '0;
        end else if (s1_zero || exp_final <= 0) begin   // flush to signed zero
            res_u.fields.exponent = '0;
            res_u.fields.mantissa = '0;
        end else if (exp_final >= EXP_MAX) begin
            res_u.fields.exponent = '1;
            res_u.fields.mantissa = '0;
            ovf_d                 = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            invalid  <= 1'b0;
            overflow <= 1'b0;
        end else if (enable) begin
            invalid  <= inv_d;
            overflow <= ovf_d;
        end
    end

    always_ff @(posedge clk) begin
        if (enable)
            result <= res_u.bits;
    end

endmodule

`default_nettype wire

// ==== src/fp_mul_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_mul_pipe
    import fp_pkg::*, mul_pipe_pkg::*;
#(
    parameter int NUM_THREADS = 4,
    parameter int TAG_W       = 6
) (
    input  wire                                         clk,
    input  wire                                         rst_n,
    input  wire                                         req_valid,
    input  wire  [TAG_W-1:0]                            req_tag,
    input  wire  [NUM_THREADS-1:0][$bits(fp32_word_u)-1:0] req_a,
    input  wire  [NUM_THREADS-1:0][$bits(fp32_word_u)-1:0] req_b,
    output logic                                        req_ready,
    output logic                                        pipe_valid,
    output logic [TAG_W-1:0]                            pipe_tag,
    output logic [NUM_THREADS-1:0][$bits(fp32_word_u)-1:0] pipe_result,
    output logic [NUM_THREADS-1:0]                      pipe_invalid,
    output logic [NUM_THREADS-1:0]                      pipe_overflow,
    input  wire                                         pipe_ready
);

    logic stall;
    logic enable;

    assign stall     = pipe_valid & ~pipe_ready;
    assign enable    = ~stall;   // one enable freezes lanes and tags together
    assign req_ready = enable;

    for (genvar i = 0; i < NUM_THREADS; i++) begin : g_lane
        fp_mul_lane lane (
            .clk      (clk),
            .rst_n    (rst_n),
            .enable   (enable),
            .a        (req_a[i]),
            .b        (req_b[i]),
            .result   (pipe_result[i]),
            .invalid  (pipe_invalid[i]),
            .overflow (pipe_overflow[i])
        );
    end

    // tag and valid travel alongside the lane stages
    logic [MUL_STAGES-1:0] sh_valid;
    logic [TAG_W-1:0]      sh_tag [MUL_STAGES];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sh_valid <= '0;
        end else if (enable) begin
            sh_valid[0] <= req_valid;
            for (int s = 1; s < MUL_STAGES; s++)
                sh_valid[s] <= sh_valid[s-1];
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            sh_tag[0] <= req_tag;
            for (int s = 1; s < MUL_STAGES; s++)
                sh_tag[s] <= sh_tag[s-1];
        end
    end

    assign pipe_valid = sh_valid[MUL_STAGES-1];
    assign pipe_tag   = sh_tag[MUL_STAGES-1];

    // back-pressure from the response queue holds the head item in place
    assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> pipe_valid && $stable(pipe_tag));

endmodule

`default_nettype wire

// ==== src/fp_mul_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_mul_unit #(
    parameter int NUM_THREADS = 4,
    parameter int TAG_W       = 6
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         in_valid,
    input  wire [TAG_W-1:0]             in_tag,
    input  wire [NUM_THREADS-1:0][31:0] dataa,
    input  wire [NUM_THREADS-1:0][31:0] datab,
    output wire                         in_ready,
    output wire                         out_valid,
    output wire [TAG_W-1:0]             out_tag,
    output wire [NUM_THREADS-1:0][31:0] result,
    output wire [NUM_THREADS-1:0]       out_invalid,
    output wire [NUM_THREADS-1:0]       out_overflow,
    input  wire                         out_ready
);

    // ========================================
    // request side to pipe
    // ========================================
    wire                         req_valid;
    wire                         req_ready;
    wire [TAG_W-1:0]             req_tag;
    wire [NUM_THREADS-1:0][31:0] req_a;
    wire [NUM_THREADS-1:0][31:0] req_b;

    // pipe to response queue
    wire                         pipe_valid;
    wire                         pipe_ready;
    wire [TAG_W-1:0]             pipe_tag;
    wire [NUM_THREADS-1:0][31:0] pipe_result;
    wire [NUM_THREADS-1:0]       pipe_invalid;
    wire [NUM_THREADS-1:0]       pipe_overflow;

    fp_req_buffer #(.NUM_THREADS(NUM_THREADS), .TAG_W(TAG_W)) req_buf (
        .clk(clk), .rst_n(rst_n),
        .in_valid(in_valid), .in_tag(in_tag), .dataa(dataa), .datab(datab),
        .in_ready(in_ready),
        .req_valid(req_valid), .req_tag(req_tag), .req_a(req_a), .req_b(req_b),
        .req_ready(req_ready)
    );

    fp_mul_pipe #(.NUM_THREADS(NUM_THREADS), .TAG_W(TAG_W)) mul_pipe (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_tag(req_tag), .req_a(req_a), .req_b(req_b),
        .req_ready(req_ready),
        .pipe_valid(pipe_valid), .pipe_tag(pipe_tag), .pipe_result(pipe_result),
        .pipe_invalid(pipe_invalid), .pipe_overflow(pipe_overflow),
        .pipe_ready(pipe_ready)
    );

    fp_resp_buffer #(.NUM_THREADS(NUM_THREADS), .TAG_W(TAG_W)) resp_buf (
        .clk(clk), .rst_n(rst_n),
        .pipe_valid(pipe_valid), .pipe_tag(pipe_tag), .pipe_result(pipe_result),
        .pipe_invalid(pipe_invalid), .pipe_overflow(pipe_overflow),
        .pipe_ready(pipe_ready),
        .out_valid(out_valid), .out_tag(out_tag), .result(result),
        .out_invalid(out_invalid), .out_overflow(out_overflow),
        .out_ready(out_ready)
    );

endmodule

`default_nettype wire

// ==== src/fp_pkg.sv ====
`default_nettype none

// ========================================
// FP32 binary format
// ========================================
package fp_pkg;

    localparam int unsigned FP_EXP_W = 8;   // exponent field width
    localparam int unsigned FP_MAN_W = 23;  // stored mantissa, hidden bit excluded
    localparam int unsigned FP_BIAS  = 127;

    // one operand word, seen either as raw bits or split into its fields.
    // the raw view serves the class checks and the result word,
    // the field view serves the exponent and mantissa arithmetic
    typedef union packed {
        logic [FP_EXP_W+FP_MAN_W:0] bits;
        struct packed {
            logic                sign;
            logic [FP_EXP_W-1:0] exponent;
            logic [FP_MAN_W-1:0] mantissa;
        } fields;
    } fp32_word_u;

endpackage

`default_nettype wire

// ==== src/fp_req_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_req_buffer #(
    parameter int NUM_THREADS = 4,
    parameter int TAG_W       = 6
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         in_valid,
    input  wire [TAG_W-1:0]             in_tag,
    input  wire [NUM_THREADS-1:0][31:0] dataa,
    input  wire [NUM_THREADS-1:0][31:0] datab,
    output logic                        in_ready,
    output logic                        req_valid,
    output logic [TAG_W-1:0]            req_tag,
    output logic [NUM_THREADS-1:0][31:0] req_a,
    output logic [NUM_THREADS-1:0][31:0] req_b,
    input  wire                         req_ready
);

    logic                         skid_valid;
    logic [TAG_W-1:0]             skid_tag;
    logic [NUM_THREADS-1:0][31:0] skid_a;
    logic [NUM_THREADS-1:0][31:0] skid_b;

    logic in_fire;
    logic main_open;     // main register empties or drains this cycle
    logic skid_valid_d;

    assign in_fire   = in_valid & in_ready;
    assign main_open = ~req_valid | req_ready;

    // skid slot fills only when input arrives while main is stuck
    assign skid_valid_d = main_open ? 1'b0 : (skid_valid | in_fire);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_valid  <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else begin
            skid_valid <= skid_valid_d;
            in_ready   <= ~skid_valid_d;   // straight from a flop
            if (main_open)
                req_valid <= skid_valid | in_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (main_open) begin
            req_tag <= skid_valid ? skid_tag : in_tag;
            req_a   <= skid_valid ? skid_a : dataa;
            req_b   <= skid_valid ? skid_b : datab;
        end
        if (in_fire && !main_open) begin
            skid_tag <= in_tag;
            skid_a   <= dataa;
            skid_b   <= datab;
        end
    end

    // an offered request is held until the pipe takes it
    assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> req_valid && $stable(req_tag));

endmodule

`default_nettype wire

// ==== src/fp_resp_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_resp_buffer
    import mul_pipe_pkg::*;
#(
    parameter int NUM_THREADS = 4,
    parameter int TAG_W       = 6
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          pipe_valid,
    input  wire  [TAG_W-1:0]             pipe_tag,
    input  wire  [NUM_THREADS-1:0][31:0] pipe_result,
    input  wire  [NUM_THREADS-1:0]       pipe_invalid,
    input  wire  [NUM_THREADS-1:0]       pipe_overflow,
    output logic                         pipe_ready,
    output logic                         out_valid,
    output logic [TAG_W-1:0]             out_tag,
    output logic [NUM_THREADS-1:0][31:0] result,
    output logic [NUM_THREADS-1:0]       out_invalid,
    output logic [NUM_THREADS-1:0]       out_overflow,
    input  wire                          out_ready
);

    localparam int PTR_W = (RESP_DEPTH > 1) ? $clog2(RESP_DEPTH) : 1;
    localparam int CNT_W = $clog2(RESP_DEPTH + 1);

    logic [TAG_W-1:0]             tag_q [RESP_DEPTH];
    logic [NUM_THREADS-1:0][31:0] res_q [RESP_DEPTH];
    logic [NUM_THREADS-1:0]       inv_q [RESP_DEPTH];
    logic [NUM_THREADS-1:0]       ovf_q [RESP_DEPTH];

    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en, rd_en;

    assign pipe_ready = count < CNT_W'(RESP_DEPTH);
    assign out_valid  = count != '0;
    assign wr_en      = pipe_valid & pipe_ready;
    assign rd_en      = out_valid & out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= (wr_ptr == PTR_W'(RESP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= (rd_ptr == PTR_W'(RESP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (wr_en && !rd_en)
                count <= count + 1'b1;
            else if (rd_en && !wr_en)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_ptr] <= pipe_tag;
            res_q[wr_ptr] <= pipe_result;
            inv_q[wr_ptr] <= pipe_invalid;
            ovf_q[wr_ptr] <= pipe_overflow;
        end
    end

    assign out_tag      = tag_q[rd_ptr];
    assign result       = res_q[rd_ptr];
    assign out_invalid  = inv_q[rd_ptr];
    assign out_overflow = ovf_q[rd_ptr];

    // a write while full or a read while empty would break count against the pointers
    assert property (@(posedge clk) disable iff (!rst_n)
        count <= CNT_W'(RESP_DEPTH)
        && ((wr_ptr == rd_ptr) == (count == '0 || count == CNT_W'(RESP_DEPTH))));

endmodule

`default_nettype wire

// ==== src/mul_pipe_pkg.sv ====
`default_nettype none

// ========================================
// multiply pipeline constants
// ========================================
package mul_pipe_pkg;

    // register stages inside one lane, input to result
    localparam int unsigned MUL_STAGES = 2;

    // entries in the response queue
    localparam int unsigned RESP_DEPTH = 2;

    // the only NaN a lane ever produces
    localparam logic [31:0] QNAN_CANON = 32'h7fc0_0000;

endpackage

`default_nettype wire
